/* hdl/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path and address width
`define CORE_WORD_LEN 32

// architectural register file
`define CORE_REG_COUNT 32
`define CORE_REG_IDX_W 5

// fetch address at which the core stops, leaves room for 16 instructions
`define CORE_EXIT_PC 32'h40

`endif

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;
    localparam logic [6:0] OPCODE_OP    = 7'b0110011;

    localparam logic [2:0] FUNCT3_WORD  = 3'b010;
    localparam logic [2:0] FUNCT3_ADD   = 3'b000;
    localparam logic [6:0] FUNCT7_ADD   = 7'b0000000;

    // I and S immediates are both 12 bits before extension
    localparam int IMM_W = 12;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // same 32-bit word, seen through each format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_word_u;

endpackage

/* hdl/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

    typedef logic [`CORE_WORD_LEN-1:0] word_t;

    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

    // anything not listed retires as OP_NOP
    typedef enum logic [1:0] {
        OP_NOP,
        OP_LW,
        OP_SW,
        OP_ADD
    } op_e;

endpackage

/* hdl/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;

    core_pkg::op_e      op;
    core_pkg::reg_idx_t rs1_idx;
    core_pkg::reg_idx_t rs2_idx;
    core_pkg::reg_idx_t rd_idx;
    // already sign extended, S form for stores
    core_pkg::word_t    imm;

    modport dec (
        output op,
        output rs1_idx,
        output rs2_idx,
        output rd_idx,
        output imm
    );

    modport exe (
        input op,
        input rs1_idx,
        input rs2_idx,
        input rd_idx,
        input imm
    );

endinterface

/* hdl/regfile_if.sv */
`timescale 1ns/1ps

interface regfile_if;

    // read side
    core_pkg::reg_idx_t rs1_idx;
    core_pkg::reg_idx_t rs2_idx;
    core_pkg::word_t    rs1_data;
    core_pkg::word_t    rs2_data;

    // write side
    logic               wr_en;
    core_pkg::reg_idx_t wr_idx;
    core_pkg::word_t    wr_data;

    modport exe (
        output rs1_idx,
        output rs2_idx,
        input  rs1_data,
        input  rs2_data,
        output wr_en,
        output wr_idx,
        output wr_data
    );

    modport rf (
        input  rs1_idx,
        input  rs2_idx,
        output rs1_data,
        output rs2_data,
        input  wr_en,
        input  wr_idx,
        input  wr_data
    );

endinterface

/* hdl/pc_unit.sv */
`timescale 1ns/1ps

`include "core_params.svh"

module pc_unit (
    input  logic            clk,
    input  logic            rst_n,
    output core_pkg::word_t pc_o,
    output logic            halted_o
);

    core_pkg::word_t pc_q;

    // halt is a level straight off the pc compare
    assign halted_o = (pc_q == `CORE_EXIT_PC);
    assign pc_o     = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!halted_o) begin
            pc_q <= pc_q + core_pkg::word_t'(4);
        end
    end

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps

`include "core_params.svh"

module inst_decoder (
    input  core_pkg::word_t inst_i,
    decode_if.dec           dec
);

    rv_isa_pkg::inst_word_u         inst;
    core_pkg::op_e                  op;
    logic [rv_isa_pkg::IMM_W-1:0]   imm_i;
    logic [rv_isa_pkg::IMM_W-1:0]   imm_s;
    core_pkg::word_t                imm_i_sext;
    core_pkg::word_t                imm_s_sext;

    assign inst = inst_i;

    always_comb begin
        op = core_pkg::OP_NOP;
        case (inst.r_fmt.opcode)
            rv_isa_pkg::OPCODE_LOAD: begin
                if (inst.i_fmt.funct3 == rv_isa_pkg::FUNCT3_WORD) begin
                    op = core_pkg::OP_LW;
                end
            end
            rv_isa_pkg::OPCODE_STORE: begin
                if (inst.s_fmt.funct3 == rv_isa_pkg::FUNCT3_WORD) begin
                    op = core_pkg::OP_SW;
                end
            end
            rv_isa_pkg::OPCODE_OP: begin
                if (inst.r_fmt.funct3 == rv_isa_pkg::FUNCT3_ADD &&
                    inst.r_fmt.funct7 == rv_isa_pkg::FUNCT7_ADD) begin
                    op = core_pkg::OP_ADD;
                end
            end
            default: begin
                op = core_pkg::OP_NOP;
            end
        endcase
    end

    // store immediate is split around rs2/rs1
    assign imm_i = inst.i_fmt.imm;
    assign imm_s = {inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};

    assign imm_i_sext = {{(`CORE_WORD_LEN-rv_isa_pkg::IMM_W){imm_i[rv_isa_pkg::IMM_W-1]}}, imm_i};
    assign imm_s_sext = {{(`CORE_WORD_LEN-rv_isa_pkg::IMM_W){imm_s[rv_isa_pkg::IMM_W-1]}}, imm_s};

    assign dec.op      = op;
    assign dec.rs1_idx = inst.r_fmt.rs1;
    assign dec.rs2_idx = inst.r_fmt.rs2;
    assign dec.rd_idx  = inst.r_fmt.rd;
    assign dec.imm     = (op == core_pkg::OP_SW) ? imm_s_sext : imm_i_sext;

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

`include "core_params.svh"

module regfile (
    input  logic  clk,
    input  logic  rst_n,
    regfile_if.rf rf
);

    core_pkg::word_t regs [`CORE_REG_COUNT];

    // x0 reads as zero whatever the array holds
    assign rf.rs1_data = (rf.rs1_idx == '0) ? '0 : regs[rf.rs1_idx];
    assign rf.rs2_data = (rf.rs2_idx == '0) ? '0 : regs[rf.rs2_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && rf.wr_idx != '0) begin
            regs[rf.wr_idx] <= rf.wr_data;
        end
    end

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic            halted_i,
    decode_if.exe           dec,
    regfile_if.exe          rf,
    output core_pkg::word_t dmem_addr_o,
    input  core_pkg::word_t dmem_rdata_i,
    output logic            dmem_wen_o,
    output core_pkg::word_t dmem_wdata_o
);

    logic            is_lw;
    logic            is_sw;
    logic            is_add;
    core_pkg::word_t operand_b;
    core_pkg::word_t sum;

    assign is_lw  = (dec.op == core_pkg::OP_LW);
    assign is_sw  = (dec.op == core_pkg::OP_SW);
    assign is_add = (dec.op == core_pkg::OP_ADD);

    assign rf.rs1_idx = dec.rs1_idx;
    assign rf.rs2_idx = dec.rs2_idx;

    // one adder serves both address and add result
    assign operand_b = is_add ? rf.rs2_data : dec.imm;
    assign sum       = rf.rs1_data + operand_b;

    assign dmem_addr_o  = sum;
    assign dmem_wdata_o = rf.rs2_data;
    assign dmem_wen_o   = is_sw && !halted_i;

    // write-back, frozen once halted
    assign rf.wr_en   = (is_lw || is_add) && !halted_i;
    assign rf.wr_idx  = dec.rd_idx;
    assign rf.wr_data = is_lw ? dmem_rdata_i : sum;

endmodule

/* hdl/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic            clk,
    input  logic            rst_n,

    // instruction memory
    output core_pkg::word_t imem_addr_o,
    input  core_pkg::word_t imem_inst_i,

    // data memory
    output core_pkg::word_t dmem_addr_o,
    input  core_pkg::word_t dmem_rdata_i,
    output logic            dmem_wen_o,
    output core_pkg::word_t dmem_wdata_o,

    output logic            exit_o
);

    logic halted;

    decode_if  decode_bus ();
    regfile_if rf_bus ();

    pc_unit pc_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc_o     (imem_addr_o),
        .halted_o (halted)
    );

    inst_decoder inst_decoder_inst (
        .inst_i (imem_inst_i),
        .dec    (decode_bus.dec)
    );

    regfile regfile_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf_bus.rf)
    );

    execute_unit execute_unit_inst (
        .halted_i     (halted),
        .dec          (decode_bus.exe),
        .rf           (rf_bus.exe),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_wen_o   (dmem_wen_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

    // exit follows the pc compare directly
    assign exit_o = halted;

endmodule

/* testbench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// 64-word data memory model where higher address bits alias
function automatic logic [5:0] mem_index(input core_pkg::word_t addr);
    return addr[7:2];
endfunction

// top bit always set so that any sum of two loaded words wraps
function automatic core_pkg::word_t fill_word(input int idx);
    return {~8'(idx), 8'(idx * 37 + 11), 8'(idx), 8'(idx ^ 8'h5a)};
endfunction

function automatic core_pkg::word_t encode_lw(
    input core_pkg::reg_idx_t rd,
    input core_pkg::reg_idx_t rs1,
    input logic [11:0]        imm
);
    rv_isa_pkg::inst_word_u w;
    w.i_fmt.imm    = imm;
    w.i_fmt.rs1    = rs1;
    w.i_fmt.funct3 = rv_isa_pkg::FUNCT3_WORD;
    w.i_fmt.rd     = rd;
    w.i_fmt.opcode = rv_isa_pkg::OPCODE_LOAD;
    return w;
endfunction

function automatic core_pkg::word_t encode_sw(
    input core_pkg::reg_idx_t rs2,
    input core_pkg::reg_idx_t rs1,
    input logic [11:0]        imm
);
    rv_isa_pkg::inst_word_u w;
    w.s_fmt.imm_hi = imm[11:5];
    w.s_fmt.rs2    = rs2;
    w.s_fmt.rs1    = rs1;
    w.s_fmt.funct3 = rv_isa_pkg::FUNCT3_WORD;
    w.s_fmt.imm_lo = imm[4:0];
    w.s_fmt.opcode = rv_isa_pkg::OPCODE_STORE;
    return w;
endfunction

function automatic core_pkg::word_t encode_add(
    input core_pkg::reg_idx_t rd,
    input core_pkg::reg_idx_t rs1,
    input core_pkg::reg_idx_t rs2
);
    rv_isa_pkg::inst_word_u w;
    w.r_fmt.funct7 = rv_isa_pkg::FUNCT7_ADD;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = rv_isa_pkg::FUNCT3_ADD;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = rv_isa_pkg::OPCODE_OP;
    return w;
endfunction

function automatic core_pkg::word_t junk_word();
    core_pkg::word_t w;
    w = $urandom;
    if ($urandom_range(0, 1) == 0) begin
        // op-imm group is not implemented
        w[6:0] = 7'b0010011;
    end else begin
        // lb is a load of the wrong width
        w[6:0]   = rv_isa_pkg::OPCODE_LOAD;
        w[14:12] = 3'b000;
    end
    return w;
endfunction

function automatic void build_program();
    int                 kind;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    logic [11:0]        imm;
    logic [5:0]         first_idx;
    // x1 gets a known memory word first
    first_idx = 6'($urandom);
    prog[0] = encode_lw(5'd1, 5'd0, {4'b0000, first_idx, 2'b00});
    for (int i = 1; i < 16; i++) begin
        kind = int'($urandom_range(0, 9));
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        imm  = 12'($urandom);
        if (kind < 3) begin
            prog[4'(i)] = encode_lw(rd, rs1, imm);
        end else if (kind < 6) begin
            prog[4'(i)] = encode_sw(rs2, rs1, imm);
        end else if (kind < 9) begin
            prog[4'(i)] = encode_add(rd, rs1, rs2);
        end else begin
            prog[4'(i)] = junk_word();
        end
    end
endfunction

// one instruction against the model registers and memory
function automatic void step_model(
    input  core_pkg::word_t inst,
    output core_pkg::word_t exp_addr,
    output core_pkg::word_t exp_wdata,
    output logic            exp_wen,
    output logic            addr_valid
);
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::word_t    rs1_val;
    core_pkg::word_t    rs2_val;
    core_pkg::word_t    imm_i;
    core_pkg::word_t    imm_s;
    opcode  = inst[6:0];
    rd      = inst[11:7];
    funct3  = inst[14:12];
    rs1     = inst[19:15];
    rs2     = inst[24:20];
    funct7  = inst[31:25];
    rs1_val = (rs1 == 5'd0) ? '0 : model_regs[rs1];
    rs2_val = (rs2 == 5'd0) ? '0 : model_regs[rs2];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    exp_addr   = '0;
    exp_wdata  = rs2_val;
    exp_wen    = 1'b0;
    addr_valid = 1'b0;
    if (opcode == 7'b0000011 && funct3 == 3'b010) begin
        exp_addr   = rs1_val + imm_i;
        addr_valid = 1'b1;
        if (rd != 5'd0) begin
            model_regs[rd] = model_mem[mem_index(exp_addr)];
        end
    end else if (opcode == 7'b0100011 && funct3 == 3'b010) begin
        exp_addr   = rs1_val + imm_s;
        addr_valid = 1'b1;
        exp_wen    = 1'b1;
        model_mem[mem_index(exp_addr)] = rs2_val;
    end else if (opcode == 7'b0110011 && funct3 == 3'b000 && funct7 == 7'b0000000) begin
        if (rd != 5'd0) begin
            model_regs[rd] = rs1_val + rs2_val;
        end
    end
endfunction

`endif

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps

`include "core_params.svh"

module tb_rv_core;

    localparam int NUM_PROGRAMS = 8;
    localparam int EXIT_LIMIT   = 40;
    localparam int HOLD_CYCLES  = 20;

    logic            clk;
    logic            rst_n;
    core_pkg::word_t imem_addr;
    core_pkg::word_t imem_inst;
    core_pkg::word_t dmem_addr;
    core_pkg::word_t dmem_rdata;
    logic            dmem_wen;
    core_pkg::word_t dmem_wdata;
    logic            exit_flag;

    core_pkg::word_t prog [16];
    core_pkg::word_t dmem [64];
    core_pkg::word_t model_mem [64];
    core_pkg::word_t model_regs [32];
    core_pkg::word_t model_pc;
    core_pkg::word_t trailer_word;
    logic            checking;
    int              value_errors;
    int              timeout_errors;

    `include "tb_program.svh"

    rv_core_top rv_core_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_inst_i  (imem_inst),
        .dmem_addr_o  (dmem_addr),
        .dmem_rdata_i (dmem_rdata),
        .dmem_wen_o   (dmem_wen),
        .dmem_wdata_o (dmem_wdata),
        .exit_o       (exit_flag)
    );

    always #4 clk = ~clk;

    // both memories answer combinationally
    // past the exit address the fetch returns a store
    assign imem_inst = !rst_n ? '0 :
                       (imem_addr < `CORE_EXIT_PC) ? prog[imem_addr[5:2]] : trailer_word;
    assign dmem_rdata = !rst_n ? '0 : dmem[mem_index(dmem_addr)];

    always @(posedge clk) begin
        if (rst_n && dmem_wen) begin
            dmem[mem_index(dmem_addr)] <= dmem_wdata;
        end
    end

    task automatic check_word(input string name, input core_pkg::word_t exp,
                              input core_pkg::word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_cycle();
        core_pkg::word_t exp_addr;
        core_pkg::word_t exp_wdata;
        logic            exp_wen;
        logic            addr_valid;
        logic            exp_exit;
        exp_exit = (model_pc == `CORE_EXIT_PC);
        check_word("imem_addr_o", model_pc, imem_addr);
        check_bit("exit_o", exp_exit, exit_flag);
        if (exp_exit) begin
            check_bit("dmem_wen_o", 1'b0, dmem_wen);
        end else begin
            step_model(prog[model_pc[5:2]], exp_addr, exp_wdata, exp_wen, addr_valid);
            check_bit("dmem_wen_o", exp_wen, dmem_wen);
            if (addr_valid) begin
                check_word("dmem_addr_o", exp_addr, dmem_addr);
            end
            if (exp_wen) begin
                check_word("dmem_wdata_o", exp_wdata, dmem_wdata);
            end
            model_pc = model_pc + 32'd4;
        end
    endtask

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        if (checking) begin
            compare_cycle();
        end
    end

    task automatic load_memories();
        for (int i = 0; i < 64; i++) begin
            dmem[6'(i)]      = fill_word(i);
            model_mem[6'(i)] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[5'(i)] = '0;
        end
    endtask

    task automatic run_program(input int num);
        bit seen_exit;
        int n;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        build_program();
        load_memories();
        repeat (16) @(posedge clk);
        #1;
        model_pc  = '0;
        rst_n     = 1'b1;
        checking  = 1'b1;
        seen_exit = 1'b0;
        for (n = 0; n < EXIT_LIMIT && !seen_exit; n++) begin
            @(negedge clk);
            seen_exit = exit_flag;
        end
        if (!seen_exit) begin
            $display("timeout: program %0d never reached the exit address", num);
            timeout_errors++;
        end
        repeat (HOLD_CYCLES) @(posedge clk);
        #1;
        checking = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h1f68));
        clk            = 1'b0;
        rst_n          = 1'b0;
        checking       = 1'b0;
        model_pc       = '0;
        value_errors   = 0;
        timeout_errors = 0;
        trailer_word   = encode_sw(5'd1, 5'd0, 12'h000);
        for (int i = 0; i < 16; i++) begin
            prog[4'(i)] = '0;
        end
        load_memories();
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(p);
        end
        $display("errors: %0d mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
+incdir+testbench
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/decode_if.sv
hdl/regfile_if.sv
hdl/pc_unit.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/execute_unit.sv
hdl/rv_core_top.sv
testbench/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
